// ==== verilog/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

  //////////////////////////////
  // widths and counts
  //////////////////////////////
  localparam int xlen         = 32;
  localparam int reg_count    = 32;
  localparam int reg_idx_bits = 5;

  // major opcode field
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  // funct3, alu group
  localparam logic [2:0] funct3_add  = 3'b000;  // also add/sub, mul, jalr
  localparam logic [2:0] funct3_sll  = 3'b001;
  localparam logic [2:0] funct3_slt  = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor  = 3'b100;
  localparam logic [2:0] funct3_sr   = 3'b101;  // srl and sra
  localparam logic [2:0] funct3_or   = 3'b110;
  localparam logic [2:0] funct3_and  = 3'b111;

  // funct3, memory and branch group
  localparam logic [2:0] funct3_lw   = 3'b010;
  localparam logic [2:0] funct3_sw   = 3'b010;
  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000;  // sub, sra, srai
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  //////////////////////////////
  // internal codes
  //////////////////////////////
  // 32 real ops plus invalid, so six bits
  typedef enum logic [5:0] {
    op_invalid = 6'd0,
    op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu,
    op_sra, op_srl, op_sll, op_mul,
    op_addi, op_andi, op_ori, op_xori, op_slti, op_sltiu,
    op_srai, op_srli, op_slli,
    op_lui, op_auipc, op_lw, op_sw, op_jal, op_jalr,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu
  } op_e;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_e;

  //////////////////////////////
  // instruction word views
  //////////////////////////////
  typedef struct packed {
    logic [6:0]              funct7;
    logic [reg_idx_bits-1:0] rs2;
    logic [reg_idx_bits-1:0] rs1;
    logic [2:0]              funct3;
    logic [reg_idx_bits-1:0] rd;
    logic [6:0]              opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]             imm_11_0;
    logic [reg_idx_bits-1:0] rs1;
    logic [2:0]              funct3;
    logic [reg_idx_bits-1:0] rd;
    logic [6:0]              opcode;
  } i_fmt_t;

  // b format shares this split
  typedef struct packed {
    logic [6:0]              imm_11_5;
    logic [reg_idx_bits-1:0] rs2;
    logic [reg_idx_bits-1:0] rs1;
    logic [2:0]              funct3;
    logic [4:0]              imm_4_0;
    logic [6:0]              opcode;
  } s_fmt_t;

  // j format shares this split
  typedef struct packed {
    logic [19:0]             imm_31_12;
    logic [reg_idx_bits-1:0] rd;
    logic [6:0]              opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    u_fmt_t u;
  } inst_u;

  //////////////////////////////
  // stage interfaces
  //////////////////////////////
  typedef struct packed {
    logic            valid;
    inst_u           inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pcplus;
  } fe_latch_t;

  typedef struct packed {
    logic                    wr_reg;
    logic [reg_idx_bits-1:0] wregno;
    logic [xlen-1:0]         regval;
  } wb_write_t;

  typedef struct packed {
    op_e                     op;
    logic [xlen-1:0]         imm;
    logic [reg_idx_bits-1:0] rs1;
    logic [reg_idx_bits-1:0] rs2;
    logic [reg_idx_bits-1:0] rd;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    is_br;
    logic                    is_jmp;
    logic                    rd_mem;
    logic                    wr_mem;
    logic                    wr_reg;
  } decode_t;

  typedef struct packed {
    logic                    valid;
    inst_u                   inst;
    logic [xlen-1:0]         pc;
    logic [xlen-1:0]         pcplus;
    op_e                     op;
    logic [xlen-1:0]         rs1_val;
    logic [xlen-1:0]         rs2_val;
    logic [xlen-1:0]         imm;
    logic                    is_br;
    logic                    is_jmp;
    logic                    rd_mem;
    logic                    wr_mem;
    logic                    wr_reg;
    logic [reg_idx_bits-1:0] rd;
  } de_latch_t;

endpackage

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
`default_nettype none

module inst_decoder
  import decode_pkg::*;
(
  input  inst_u   inst,
  output decode_t dec
);

  logic [6:0] opcode;
  logic [2:0] f3;
  logic [6:0] f7;
  op_e        op;
  imm_e       imm_kind;
  logic       writes;    // op class writes rd

  assign opcode = inst.r.opcode;
  assign f3     = inst.r.funct3;
  assign f7     = inst.r.funct7;

  //////////////////////////////
  // opcode match
  //////////////////////////////
  always_comb begin
    if (opcode == opc_op && f3 == funct3_add && f7 == funct7_base)        op = op_add;
    else if (opcode == opc_op && f3 == funct3_add && f7 == funct7_alt)    op = op_sub;
    else if (opcode == opc_op && f3 == funct3_and && f7 == funct7_base)   op = op_and;
    else if (opcode == opc_op && f3 == funct3_or && f7 == funct7_base)    op = op_or;
    else if (opcode == opc_op && f3 == funct3_xor && f7 == funct7_base)   op = op_xor;
    else if (opcode == opc_op && f3 == funct3_slt && f7 == funct7_base)   op = op_slt;
    else if (opcode == opc_op && f3 == funct3_sltu && f7 == funct7_base)  op = op_sltu;
    else if (opcode == opc_op && f3 == funct3_sr && f7 == funct7_alt)     op = op_sra;
    else if (opcode == opc_op && f3 == funct3_sr && f7 == funct7_base)    op = op_srl;
    else if (opcode == opc_op && f3 == funct3_sll && f7 == funct7_base)   op = op_sll;
    else if (opcode == opc_op && f3 == funct3_add && f7 == funct7_muldiv) op = op_mul;
    else if (opcode == opc_op_imm && f3 == funct3_add)                    op = op_addi;
    else if (opcode == opc_op_imm && f3 == funct3_and)                    op = op_andi;
    else if (opcode == opc_op_imm && f3 == funct3_or)                     op = op_ori;
    else if (opcode == opc_op_imm && f3 == funct3_xor)                    op = op_xori;
    else if (opcode == opc_op_imm && f3 == funct3_slt)                    op = op_slti;
    else if (opcode == opc_op_imm && f3 == funct3_sltu)                   op = op_sltiu;
    else if (opcode == opc_op_imm && f3 == funct3_sr && f7 == funct7_alt) op = op_srai;
    else if (opcode == opc_op_imm && f3 == funct3_sr && f7 == funct7_base)
      op = op_srli;
    else if (opcode == opc_op_imm && f3 == funct3_sll && f7 == funct7_base)
      op = op_slli;
    else if (opcode == opc_lui)                                           op = op_lui;
    else if (opcode == opc_auipc)                                         op = op_auipc;
    else if (opcode == opc_load && f3 == funct3_lw)                       op = op_lw;
    else if (opcode == opc_store && f3 == funct3_sw)                      op = op_sw;
    else if (opcode == opc_jal)                                           op = op_jal;
    else if (opcode == opc_jalr && f3 == funct3_add)                      op = op_jalr;
    else if (opcode == opc_branch && f3 == funct3_beq)                    op = op_beq;
    else if (opcode == opc_branch && f3 == funct3_bne)                    op = op_bne;
    else if (opcode == opc_branch && f3 == funct3_blt)                    op = op_blt;
    else if (opcode == opc_branch && f3 == funct3_bge)                    op = op_bge;
    else if (opcode == opc_branch && f3 == funct3_bltu)                   op = op_bltu;
    else if (opcode == opc_branch && f3 == funct3_bgeu)                   op = op_bgeu;
    else                                                                  op = op_invalid;
  end

  // format class from op
  always_comb begin
    imm_kind    = imm_none;
    dec.use_rs1 = 1'b0;
    dec.use_rs2 = 1'b0;
    writes      = 1'b0;
    case (op)
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu,
      op_sra, op_srl, op_sll, op_mul: begin
        dec.use_rs1 = 1'b1;
        dec.use_rs2 = 1'b1;
        writes      = 1'b1;
      end
      op_addi, op_andi, op_ori, op_xori, op_slti, op_sltiu,
      op_srai, op_srli, op_slli, op_lw, op_jalr: begin
        imm_kind    = imm_i;
        dec.use_rs1 = 1'b1;
        writes      = 1'b1;
      end
      op_lui, op_auipc: begin
        imm_kind = imm_u;
        writes   = 1'b1;
      end
      op_jal: begin
        imm_kind = imm_j;
        writes   = 1'b1;
      end
      op_sw: begin
        imm_kind    = imm_s;
        dec.use_rs1 = 1'b1;
        dec.use_rs2 = 1'b1;
      end
      op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
        imm_kind    = imm_b;
        dec.use_rs1 = 1'b1;
        dec.use_rs2 = 1'b1;
      end
      default: ;  // invalid, nothing used
    endcase
  end

  // sign-extended immediate
  always_comb begin
    case (imm_kind)
      imm_i:   dec.imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
      imm_s:   dec.imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      imm_b:   dec.imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_4_0[0],
                          inst.s.imm_11_5[5:0], inst.s.imm_4_0[4:1], 1'b0};
      imm_u:   dec.imm = {inst.u.imm_31_12, 12'b0};
      imm_j:   dec.imm = {{12{inst.u.imm_31_12[19]}}, inst.u.imm_31_12[7:0],
                          inst.u.imm_31_12[8], inst.u.imm_31_12[18:9], 1'b0};
      default: dec.imm = '0;
    endcase
  end

  assign dec.op     = op;
  assign dec.rs1    = inst.r.rs1;
  assign dec.rs2    = inst.r.rs2;
  assign dec.rd     = inst.r.rd;
  assign dec.is_br  = (imm_kind == imm_b);
  assign dec.is_jmp = (op == op_jal) || (op == op_jalr);
  assign dec.rd_mem = (op == op_lw);
  assign dec.wr_mem = (op == op_sw);
  assign dec.wr_reg = writes && (inst.r.rd != '0);  // x0 target never written

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`default_nettype none

module reg_file
  import decode_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [reg_idx_bits-1:0] rs1,
  input  logic [reg_idx_bits-1:0] rs2,
  input  wb_write_t               wb,
  output logic [xlen-1:0]         rs1_val,
  output logic [xlen-1:0]         rs2_val
);

  logic [xlen-1:0]         regs [1:reg_count-1];  // no storage for x0
  logic [reg_idx_bits-1:0] rd_idx [2];
  logic [xlen-1:0]         rd_val [2];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int r = 1; r < reg_count; r++) regs[r] <= '0;
    end else if (wb.wr_reg && wb.wregno != '0) begin
      regs[wb.wregno] <= wb.regval;
    end
  end

  assign rd_idx[0] = rs1;
  assign rd_idx[1] = rs2;

  // both read ports, with same-cycle writeback bypass
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      if (rd_idx[p] == '0)
        rd_val[p] = '0;
      else if (wb.wr_reg && wb.wregno == rd_idx[p])
        rd_val[p] = wb.regval;
      else
        rd_val[p] = regs[rd_idx[p]];
    end
  end

  assign rs1_val = rd_val[0];
  assign rs2_val = rd_val[1];

  a_x0_zero: assert property (@(posedge clk) disable iff (reset)
    ((rs1 == '0) |-> (rs1_val == '0)) and ((rs2 == '0) |-> (rs2_val == '0)));

endmodule

`default_nettype wire

// ==== verilog/hazard_scoreboard.sv ====
`default_nettype none

module hazard_scoreboard
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      valid,
  input  logic      stall,
  input  decode_t   dec,
  input  wb_write_t wb,
  output logic      hazard
);

  logic [reg_count-1:0] busy;  // write still in flight

  //////////////////////////////
  // pending-write bits
  //////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (wb.wr_reg)
        busy[wb.wregno] <= 1'b0;
      // issue after retire, so a new writer of the same reg keeps it busy
      if (valid && !stall && dec.wr_reg)
        busy[dec.rd] <= 1'b1;
    end
  end

  // raw check on the sources actually read
  assign hazard = (dec.use_rs1 && busy[dec.rs1]) ||
                  (dec.use_rs2 && busy[dec.rs2]);

  // writeback only retires an issued writer
  a_wb_pending: assert property (@(posedge clk) disable iff (reset)
    (wb.wr_reg && wb.wregno != '0) |-> busy[wb.wregno]);

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
`default_nettype none

module decode_stage
  import decode_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  fe_latch_t fe_latch,
  input  wb_write_t wb,
  input  logic      br_mispred,
  output logic      stall,
  output de_latch_t de_latch
);

  decode_t         dec;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic            hazard;
  de_latch_t       de_next;

  //////////////////////////////
  // decode and operand read
  //////////////////////////////
  inst_decoder u_dec (
    .inst (fe_latch.inst),
    .dec  (dec)
  );

  reg_file u_rf (
    .clk     (clk),
    .reset   (reset),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .wb      (wb),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  hazard_scoreboard u_sb (
    .clk    (clk),
    .reset  (reset),
    .valid  (fe_latch.valid),
    .stall  (stall),
    .dec    (dec),
    .wb     (wb),
    .hazard (hazard)
  );

  // fetch holds its latch while this is high
  assign stall = br_mispred || (fe_latch.valid && hazard);

  always_comb begin
    de_next.valid   = fe_latch.valid;
    de_next.inst    = fe_latch.inst;
    de_next.pc      = fe_latch.pc;
    de_next.pcplus  = fe_latch.pcplus;
    de_next.op      = dec.op;
    de_next.rs1_val = rs1_val;
    de_next.rs2_val = rs2_val;
    de_next.imm     = dec.imm;
    de_next.is_br   = dec.is_br;
    de_next.is_jmp  = dec.is_jmp;
    de_next.rd_mem  = dec.rd_mem;
    de_next.wr_mem  = dec.wr_mem;
    de_next.wr_reg  = dec.wr_reg;
    de_next.rd      = dec.rd;
  end

  //////////////////////////////
  // decode latch
  //////////////////////////////
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      de_latch <= '0;
    else if (stall)
      de_latch <= '0;  // bubble
    else
      de_latch <= de_next;
  end

  a_stall_bubble: assert property (@(posedge clk) disable iff (reset)
    stall |=> !de_latch.valid);

endmodule

`default_nettype wire

// ==== tests/decode_stage_tb.sv ====
`default_nettype none

module decode_stage_tb
  import decode_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_cycles = 3000;  // tests need about 900
  localparam int rand_cycles = 850;

  logic      clk = 1'b0;
  logic      reset;
  fe_latch_t fe_latch;
  wb_write_t wb;
  logic      br_mispred;
  logic      stall;
  de_latch_t de_latch;

  logic [xlen-1:0]      m_regs [reg_count];  // model register file
  logic [reg_count-1:0] busy;                // model pending writes
  de_latch_t            exp_latch;
  logic                 exp_stall;
  logic                 checking = 1'b0;
  fe_latch_t            last_fe;
  logic                 last_stall = 1'b0;
  int                   cycles = 0;

  decode_stage dut0 (
    .clk        (clk),
    .reset      (reset),
    .fe_latch   (fe_latch),
    .wb         (wb),
    .br_mispred (br_mispred),
    .stall      (stall),
    .de_latch   (de_latch)
  );

  always #50 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles)
      fail_run("timeout, the run did not finish within the cycle limit");
  end

  ////////////////////////////////
  // reference decode
  ////////////////////////////////
  function automatic de_latch_t ref_decode(input fe_latch_t fe);
    de_latch_t   e;
    logic [31:0] w;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        wr;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    w     = fe.inst;
    f7    = w[31:25];
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    e = '0;
    wr = 1'b0;
    e.valid   = fe.valid;
    e.inst    = fe.inst;
    e.pc      = fe.pc;
    e.pcplus  = fe.pcplus;
    e.rd      = w[11:7];
    e.rs1_val = m_regs[w[19:15]];  // read even when unused
    e.rs2_val = m_regs[w[24:20]];
    e.op      = op_invalid;
    case (w[6:0])
      opc_op: begin
        case ({f7, f3})
          {funct7_base, funct3_add}:   e.op = op_add;
          {funct7_alt, funct3_add}:    e.op = op_sub;
          {funct7_base, funct3_and}:   e.op = op_and;
          {funct7_base, funct3_or}:    e.op = op_or;
          {funct7_base, funct3_xor}:   e.op = op_xor;
          {funct7_base, funct3_slt}:   e.op = op_slt;
          {funct7_base, funct3_sltu}:  e.op = op_sltu;
          {funct7_alt, funct3_sr}:     e.op = op_sra;
          {funct7_base, funct3_sr}:    e.op = op_srl;
          {funct7_base, funct3_sll}:   e.op = op_sll;
          {funct7_muldiv, funct3_add}: e.op = op_mul;
          default: ;
        endcase
        wr = (e.op != op_invalid);
      end
      opc_op_imm: begin
        case (f3)
          funct3_add:  e.op = op_addi;
          funct3_and:  e.op = op_andi;
          funct3_or:   e.op = op_ori;
          funct3_xor:  e.op = op_xori;
          funct3_slt:  e.op = op_slti;
          funct3_sltu: e.op = op_sltiu;
          funct3_sll:  if (f7 == funct7_base) e.op = op_slli;
          default: begin  // shift right, logical or arithmetic
            if (f7 == funct7_base) e.op = op_srli;
            else if (f7 == funct7_alt) e.op = op_srai;
          end
        endcase
        if (e.op != op_invalid) begin
          e.imm = imm_i;
          wr    = 1'b1;
        end
      end
      opc_lui, opc_auipc: begin
        e.op  = (w[6:0] == opc_lui) ? op_lui : op_auipc;
        e.imm = imm_u;
        wr    = 1'b1;
      end
      opc_load: if (f3 == funct3_lw) begin
        e.op     = op_lw;
        e.imm    = imm_i;
        e.rd_mem = 1'b1;
        wr       = 1'b1;
      end
      opc_store: if (f3 == funct3_sw) begin
        e.op     = op_sw;
        e.imm    = imm_s;
        e.wr_mem = 1'b1;
      end
      opc_jal: begin
        e.op     = op_jal;
        e.imm    = imm_j;
        e.is_jmp = 1'b1;
        wr       = 1'b1;
      end
      opc_jalr: if (f3 == 3'b000) begin
        e.op     = op_jalr;
        e.imm    = imm_i;
        e.is_jmp = 1'b1;
        wr       = 1'b1;
      end
      opc_branch: begin
        case (f3)
          funct3_beq:  e.op = op_beq;
          funct3_bne:  e.op = op_bne;
          funct3_blt:  e.op = op_blt;
          funct3_bge:  e.op = op_bge;
          funct3_bltu: e.op = op_bltu;
          funct3_bgeu: e.op = op_bgeu;
          default: ;
        endcase
        if (e.op != op_invalid) begin
          e.imm   = imm_b;
          e.is_br = 1'b1;
        end
      end
      default: ;
    endcase
    e.wr_reg = wr && (w[11:7] != 5'd0);
    return e;
  endfunction

  // which sources an op reads, {rs1, rs2}
  function automatic logic [1:0] src_use(input op_e op);
    case (op)
      op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu, op_sra, op_srl,
      op_sll, op_mul, op_sw, op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu:
        return 2'b11;
      op_addi, op_andi, op_ori, op_xori, op_slti, op_sltiu, op_srai, op_srli,
      op_slli, op_lw, op_jalr:
        return 2'b10;
      default:
        return 2'b00;
    endcase
  endfunction

  function automatic fe_latch_t make_fe(input logic v, input logic [31:0] w,
                                        input logic [31:0] pc);
    fe_latch_t f;
    f.valid  = v;
    f.inst   = w;
    f.pc     = pc;
    f.pcplus = pc + 32'd4;
    return f;
  endfunction

  function automatic wb_write_t make_wb(input logic en, input logic [4:0] r,
                                        input logic [31:0] v);
    wb_write_t b;
    b.wr_reg = en;
    b.wregno = r;
    b.regval = v;
    return b;
  endfunction

  // random word, mostly steered onto a kept encoding
  function automatic logic [31:0] rand_inst();
    logic [31:0] w;
    w = $urandom();
    case ($urandom_range(0, 9))
      0: begin
        w[6:0] = opc_op;
        case ($urandom_range(0, 2))
          0:       w[31:25] = funct7_base;
          1:       w[31:25] = funct7_alt;
          default: w[31:25] = funct7_muldiv;
        endcase
      end
      1: begin
        w[6:0] = opc_op_imm;
        if ($urandom_range(0, 1))
          w[31:25] = $urandom_range(0, 1) ? funct7_base : funct7_alt;
      end
      2: w[6:0] = opc_lui;
      3: w[6:0] = opc_auipc;
      4: begin
        w[6:0] = opc_load;
        if ($urandom_range(0, 3) != 0) w[14:12] = funct3_lw;
      end
      5: begin
        w[6:0] = opc_store;
        if ($urandom_range(0, 3) != 0) w[14:12] = funct3_sw;
      end
      6: w[6:0] = opc_jal;
      7: begin
        w[6:0] = opc_jalr;
        if ($urandom_range(0, 3) != 0) w[14:12] = 3'b000;
      end
      8: w[6:0] = opc_branch;
      default: ;  // raw word, usually invalid
    endcase
    if ($urandom_range(0, 1)) begin  // low registers, more hazards
      w[24:23] = 2'b00;
      w[19:18] = 2'b00;
      w[11:10] = 2'b00;
    end
    return w;
  endfunction

  // drive one cycle on the falling edge and advance the model
  task automatic step(input fe_latch_t fe, input wb_write_t wbw, input logic mis);
    de_latch_t   e;
    logic [1:0]  srcs;
    logic        haz;
    logic [31:0] w;
    @(negedge clk);
    fe_latch   = fe;
    wb         = wbw;
    br_mispred = mis;
    w = fe.inst;
    if (wbw.wr_reg && wbw.wregno != 5'd0) m_regs[wbw.wregno] = wbw.regval;
    e    = ref_decode(fe);
    srcs = src_use(e.op);
    haz  = (srcs[1] && busy[w[19:15]]) || (srcs[0] && busy[w[24:20]]);
    exp_stall = mis || (fe.valid && haz);
    exp_latch = exp_stall ? '0 : e;
    if (wbw.wr_reg) busy[wbw.wregno] = 1'b0;
    if (fe.valid && !exp_stall && e.wr_reg) busy[e.rd] = 1'b1;  // set wins
    checking   = 1'b1;
    last_fe    = fe;
    last_stall = exp_stall;
  endtask

  task automatic check_val(input string name, input logic [255:0] got,
                           input logic [255:0] exp);
    assert (got === exp)
    else fail_run($sformatf("[ERROR] %s got %0h expected %0h", name, got, exp));
  endtask

  ////////////////////////////////
  // comparing process
  ////////////////////////////////
  initial begin
    forever begin
      @(negedge clk);
      #40;  // just before the rising edge
      if (checking) check_val("stall", stall, exp_stall);
      @(posedge clk);
      #10;
      if (checking) begin
        check_val("de_latch.valid", de_latch.valid, exp_latch.valid);
        check_val("de_latch.inst", de_latch.inst, exp_latch.inst);
        check_val("de_latch.pc", de_latch.pc, exp_latch.pc);
        check_val("de_latch.pcplus", de_latch.pcplus, exp_latch.pcplus);
        check_val("de_latch.op", de_latch.op, exp_latch.op);
        check_val("de_latch.rs1_val", de_latch.rs1_val, exp_latch.rs1_val);
        check_val("de_latch.rs2_val", de_latch.rs2_val, exp_latch.rs2_val);
        check_val("de_latch.imm", de_latch.imm, exp_latch.imm);
        check_val("de_latch.flags",
                  {de_latch.is_br, de_latch.is_jmp, de_latch.rd_mem,
                   de_latch.wr_mem, de_latch.wr_reg},
                  {exp_latch.is_br, exp_latch.is_jmp, exp_latch.rd_mem,
                   exp_latch.wr_mem, exp_latch.wr_reg});
        check_val("de_latch.rd", de_latch.rd, exp_latch.rd);
      end
    end
  end

  ////////////////////////////////
  // stimulus
  ////////////////////////////////
  initial begin
    fe_latch_t   fe;
    wb_write_t   wbw;
    logic        mis;
    int          r;
    int          s;
    logic [31:0] pc;
    logic [31:0] add_x8;
    r = $urandom(4);
    reset      = 1'b1;
    fe_latch   = '0;
    wb         = '0;
    br_mispred = 1'b0;
    busy       = '0;
    exp_latch  = '0;
    exp_stall  = 1'b0;
    pc         = 32'h0000_1000;
    for (int i = 0; i < reg_count; i++) m_regs[i] = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_val("de_latch", de_latch, '0);
    check_val("stall", stall, 1'b0);
    step('0, '0, 1'b0);

    // raw hazard on x7, then operand arrives
    add_x8 = {funct7_base, 5'd7, 5'd7, funct3_add, 5'd8, opc_op};
    step(make_fe(1'b1, {12'd5, 5'd0, funct3_add, 5'd7, opc_op_imm}, pc), '0, 1'b0);
    step(make_fe(1'b1, add_x8, pc + 4), '0, 1'b0);
    step(make_fe(1'b1, add_x8, pc + 4), make_wb(1'b1, 5'd7, 32'hcafe_f00d), 1'b0);
    step(make_fe(1'b1, add_x8, pc + 4), '0, 1'b0);
    // mispredict bubble, then same word passes
    fe = make_fe(1'b1, {12'h0f0, 5'd1, funct3_xor, 5'd9, opc_op_imm}, pc + 8);
    step(fe, '0, 1'b1);
    step(fe, '0, 1'b0);
    // lui carries x8 in both source fields, written back this cycle
    step(make_fe(1'b1, {7'd0, 5'd8, 5'd8, 3'b000, 5'd11, opc_lui}, pc + 12),
         make_wb(1'b1, 5'd8, 32'h1234_5678), 1'b0);
    // x0 stays zero, addi to x0 does not write
    step(make_fe(1'b1, {funct7_base, 5'd0, 5'd0, funct3_add, 5'd10, opc_op}, pc + 16),
         make_wb(1'b1, 5'd0, 32'hffff_ffff), 1'b0);
    step(make_fe(1'b1, {12'h7ff, 5'd0, funct3_add, 5'd0, opc_op_imm}, pc + 20), '0, 1'b0);
    pc = pc + 20;

    for (int n = 0; n < rand_cycles; n++) begin
      if (last_stall) begin
        fe = last_fe;  // fetch holds while stalled
      end else begin
        pc = pc + 4;
        fe = make_fe($urandom_range(0, 9) != 0, rand_inst(), pc);
      end
      wbw = '0;
      if (busy != '0 && $urandom_range(0, 1)) begin
        r = -1;
        s = $urandom_range(0, reg_count - 1);
        for (int i = 0; i < reg_count; i++)
          if (r < 0 && busy[(s + i) % reg_count]) r = (s + i) % reg_count;
        wbw = make_wb(1'b1, r[4:0], $urandom());
      end else if ($urandom_range(0, 19) == 0) begin
        wbw = make_wb(1'b1, 5'd0, $urandom());
      end
      mis = ($urandom_range(0, 11) == 0);
      step(fe, wbw, mis);
    end

    step('0, '0, 1'b0);
    step('0, '0, 1'b0);
    @(posedge clk);
    #20;
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== decode_stage.f ====
verilog/decode_pkg.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/hazard_scoreboard.sv
verilog/decode_stage.sv
tests/decode_stage_tb.sv
